// ==== logic/dc_settings.svh ====
// Data cache geometry
// Two-way set-associative, 16-byte lines, 15-bit physical address
// split into tag, set index and byte offset

`ifndef DC_SETTINGS_SVH
`define DC_SETTINGS_SVH

// Address fields
`define DC_ADDR_W   15
`define DC_TAG_W    7
`define DC_INDEX_W  4
`define DC_OFFSET_W 4

// Core word and cache line
`define DC_WORD_W   32
`define DC_LINE_W   128

`define DC_SETS     16

`endif

// ==== logic/dc_pkg.sv ====
// Data cache types
// Core request and response, tag entry, memory request and controller states

`default_nettype none

`include "dc_settings.svh"

package dc_pkg;

  // Core load or store, one aligned word
  typedef struct packed {
    logic                    write;
    logic [`DC_ADDR_W-1:0]   addr;
    logic [`DC_WORD_W-1:0]   wdata;
  } dc_req_t;

  typedef struct packed {
    logic [`DC_WORD_W-1:0] rdata;
  } dc_rsp_t;

  // One way's entry for one set
  typedef struct packed {
    logic                  valid;
    logic                  dirty;
    logic [`DC_TAG_W-1:0]  tag;
  } dc_tag_t;

  // Fill request, with the dirty victim riding along when evict is set
  typedef struct packed {
    logic [`DC_ADDR_W-1:0]  fill_addr;
    logic                   evict;
    logic [`DC_ADDR_W-1:0]  evict_addr;
    logic [`DC_LINE_W-1:0]  evict_data;
  } dc_mem_req_t;

  typedef enum logic [1:0] {IDLE, LOOKUP, REFILL} dc_state_e;

endpackage

`default_nettype wire

// ==== logic/dc_way_ram.sv ====
// Data cache way storage
// One entry per set, read without a clock, written on the rising edge.
// Serves both the tag store and the line store through entry_t

`timescale 1ns/1ps
`default_nettype none

`include "dc_settings.svh"

module dc_way_ram #(
  parameter type entry_t = logic
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`DC_INDEX_W-1:0]  index,
  input  logic                    wr_en,
  input  entry_t                  wr_data,
  output entry_t                  rd_data
);

  entry_t mem [0:`DC_SETS-1];

  // Reset clears every set so valid and dirty bits start low
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `DC_SETS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[index] <= wr_data;
    end
  end

  // Asynchronous read of the addressed set
  assign rd_data = mem[index];

endmodule

`default_nettype wire

// ==== logic/dc_lookup.sv ====
// Data cache lookup
// Tag compare on both ways, victim choice, word select for loads
// and store-word merge into the hit line

`timescale 1ns/1ps
`default_nettype none

`include "dc_settings.svh"

module dc_lookup (
  input  dc_pkg::dc_req_t          req,
  input  dc_pkg::dc_tag_t          tag_way0,
  input  dc_pkg::dc_tag_t          tag_way1,
  input  logic [`DC_LINE_W-1:0]    line_way0,
  input  logic [`DC_LINE_W-1:0]    line_way1,
  input  logic                     lru,
  output logic                     hit,
  output logic                     hit_way,
  output logic                     victim_way,
  output logic                     victim_dirty,
  output logic [`DC_TAG_W-1:0]     victim_tag,
  output logic [`DC_LINE_W-1:0]    victim_line,
  output logic [`DC_WORD_W-1:0]    rd_word,
  output logic [`DC_LINE_W-1:0]    merged_line
);

  logic [`DC_TAG_W-1:0]   req_tag;
  logic [1:0]             word_sel;
  logic                   hit0;
  logic                   hit1;
  logic [`DC_LINE_W-1:0]  hit_line;
  dc_pkg::dc_tag_t        victim_entry;

  assign req_tag  = req.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign word_sel = req.addr[`DC_OFFSET_W-1:2];

  assign hit0    = tag_way0.valid && (tag_way0.tag == req_tag);
  assign hit1    = tag_way1.valid && (tag_way1.tag == req_tag);
  assign hit     = hit0 || hit1;
  assign hit_way = hit1;

  // Invalid way first, LRU only when the set is full
  always_comb begin
    if (!tag_way0.valid) begin
      victim_way = 1'b0;
    end else if (!tag_way1.valid) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru;
    end
  end

  assign victim_entry = victim_way ? tag_way1 : tag_way0;
  assign victim_dirty = victim_entry.valid && victim_entry.dirty;
  assign victim_tag   = victim_entry.tag;
  assign victim_line  = victim_way ? line_way1 : line_way0;

  assign hit_line = hit_way ? line_way1 : line_way0;
  assign rd_word  = hit_line[word_sel*`DC_WORD_W +: `DC_WORD_W];

  // Store word replaces one word of the hit line
  always_comb begin
    merged_line = hit_line;
    merged_line[word_sel*`DC_WORD_W +: `DC_WORD_W] = req.wdata;
  end

endmodule

`default_nettype wire

// ==== logic/dc_ctrl.sv ====
// Data cache controller
// IDLE/LOOKUP/REFILL state machine, holds the accepted request and the
// per-set LRU bits, steers array writes and the line fill request

`timescale 1ns/1ps
`default_nettype none

`include "dc_settings.svh"

module dc_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  dc_pkg::dc_req_t          req,
  input  logic                     req_valid,
  output logic                     req_ready,
  output dc_pkg::dc_req_t          cur_req,
  output logic                     lru,
  input  logic                     hit,
  input  logic                     hit_way,
  input  logic                     victim_way,
  input  logic                     victim_dirty,
  input  logic [`DC_TAG_W-1:0]     victim_tag,
  input  logic [`DC_LINE_W-1:0]    victim_line,
  input  logic [`DC_WORD_W-1:0]    rd_word,
  input  logic [`DC_LINE_W-1:0]    merged_line,
  output logic [1:0]               tag_wr_en,
  output dc_pkg::dc_tag_t          tag_wr_data,
  output logic [1:0]               line_wr_en,
  output logic [`DC_LINE_W-1:0]    line_wr_data,
  output dc_pkg::dc_rsp_t          rsp,
  output logic                     rsp_valid,
  output dc_pkg::dc_mem_req_t      mem_req,
  output logic                     mem_req_valid,
  input  logic                     mem_ack,
  input  logic [`DC_LINE_W-1:0]    mem_fill
);

  dc_pkg::dc_state_e        state;
  logic [`DC_SETS-1:0]      lru_bits;
  logic                     fill_way;
  logic [`DC_INDEX_W-1:0]   cur_index;
  logic [`DC_TAG_W-1:0]     cur_tag;

  assign cur_index = cur_req.addr[`DC_OFFSET_W +: `DC_INDEX_W];
  assign cur_tag   = cur_req.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign req_ready = (state == dc_pkg::IDLE);
  assign lru       = lru_bits[cur_index];

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= dc_pkg::IDLE;
      rsp_valid     <= 1'b0;
      mem_req_valid <= 1'b0;
      lru_bits      <= '0;
    end else begin
      rsp_valid <= 1'b0;
      case (state)
        dc_pkg::IDLE: begin
          if (req_valid) begin
            state <= dc_pkg::LOOKUP;
          end
        end
        dc_pkg::LOOKUP: begin
          if (hit) begin
            state               <= dc_pkg::IDLE;
            rsp_valid           <= 1'b1;
            lru_bits[cur_index] <= ~hit_way;
          end else begin
            state         <= dc_pkg::REFILL;
            mem_req_valid <= 1'b1;
          end
        end
        dc_pkg::REFILL: begin
          // Fill lands now, the retry in LOOKUP then hits
          if (mem_ack) begin
            state         <= dc_pkg::LOOKUP;
            mem_req_valid <= 1'b0;
          end
        end
        default: state <= dc_pkg::IDLE;
      endcase
    end
  end

  // Request, read data and miss payload
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      cur_req <= req;
    end
    if (state == dc_pkg::LOOKUP && hit) begin
      rsp.rdata <= rd_word;
    end
    if (state == dc_pkg::LOOKUP && !hit) begin
      fill_way           <= victim_way;
      mem_req.fill_addr  <= {cur_tag, cur_index, {`DC_OFFSET_W{1'b0}}};
      mem_req.evict      <= victim_dirty;
      mem_req.evict_addr <= {victim_tag, cur_index, {`DC_OFFSET_W{1'b0}}};
      mem_req.evict_data <= victim_line;
    end
  end

  // Array writes, store hit or line fill
  always_comb begin
    tag_wr_en    = 2'b00;
    line_wr_en   = 2'b00;
    tag_wr_data  = '{valid: 1'b1, dirty: 1'b1, tag: cur_tag};
    line_wr_data = merged_line;
    if (state == dc_pkg::LOOKUP && hit && cur_req.write) begin
      // Read hits leave the tag entry as it is
      tag_wr_en[hit_way]  = 1'b1;
      line_wr_en[hit_way] = 1'b1;
    end else if (state == dc_pkg::REFILL && mem_ack) begin
      tag_wr_en[fill_way]  = 1'b1;
      line_wr_en[fill_way] = 1'b1;
      tag_wr_data.dirty    = 1'b0;
      line_wr_data         = mem_fill;
    end
  end

endmodule

`default_nettype wire

// ==== logic/dcache.sv ====
// Two-way set-associative write-back data cache
// Controller, lookup logic and two ways of tag and line storage

`timescale 1ns/1ps
`default_nettype none

`include "dc_settings.svh"

module dcache (
  input  logic                     clk,
  input  logic                     rst,
  input  dc_pkg::dc_req_t          req,
  input  logic                     req_valid,
  output logic                     req_ready,
  output dc_pkg::dc_rsp_t          rsp,
  output logic                     rsp_valid,
  output dc_pkg::dc_mem_req_t      mem_req,
  output logic                     mem_req_valid,
  input  logic                     mem_ack,
  input  logic [`DC_LINE_W-1:0]    mem_fill
);

  dc_pkg::dc_req_t         cur_req;
  logic                    lru;
  dc_pkg::dc_tag_t         tag_way0;
  dc_pkg::dc_tag_t         tag_way1;
  logic [`DC_LINE_W-1:0]   line_way0;
  logic [`DC_LINE_W-1:0]   line_way1;
  logic [1:0]              tag_wr_en;
  dc_pkg::dc_tag_t         tag_wr_data;
  logic [1:0]              line_wr_en;
  logic [`DC_LINE_W-1:0]   line_wr_data;
  logic                    hit;
  logic                    hit_way;
  logic                    victim_way;
  logic                    victim_dirty;
  logic [`DC_TAG_W-1:0]    victim_tag;
  logic [`DC_LINE_W-1:0]   victim_line;
  logic [`DC_WORD_W-1:0]   rd_word;
  logic [`DC_LINE_W-1:0]   merged_line;

  dc_ctrl ctrl_i (
    .clk(clk), .rst(rst),
    .req(req), .req_valid(req_valid), .req_ready(req_ready),
    .cur_req(cur_req), .lru(lru),
    .hit(hit), .hit_way(hit_way),
    .victim_way(victim_way), .victim_dirty(victim_dirty),
    .victim_tag(victim_tag), .victim_line(victim_line),
    .rd_word(rd_word), .merged_line(merged_line),
    .tag_wr_en(tag_wr_en), .tag_wr_data(tag_wr_data),
    .line_wr_en(line_wr_en), .line_wr_data(line_wr_data),
    .rsp(rsp), .rsp_valid(rsp_valid),
    .mem_req(mem_req), .mem_req_valid(mem_req_valid),
    .mem_ack(mem_ack), .mem_fill(mem_fill)
  );

  dc_lookup lookup_i (
    .req(cur_req), .tag_way0(tag_way0), .tag_way1(tag_way1),
    .line_way0(line_way0), .line_way1(line_way1), .lru(lru),
    .hit(hit), .hit_way(hit_way),
    .victim_way(victim_way), .victim_dirty(victim_dirty),
    .victim_tag(victim_tag), .victim_line(victim_line),
    .rd_word(rd_word), .merged_line(merged_line)
  );

  // Tag store, one RAM per way
  dc_way_ram #(.entry_t(dc_pkg::dc_tag_t)) tag_way0_i (
    .clk(clk), .rst(rst), .index(cur_req.addr[`DC_OFFSET_W +: `DC_INDEX_W]),
    .wr_en(tag_wr_en[0]), .wr_data(tag_wr_data), .rd_data(tag_way0)
  );

  dc_way_ram #(.entry_t(dc_pkg::dc_tag_t)) tag_way1_i (
    .clk(clk), .rst(rst), .index(cur_req.addr[`DC_OFFSET_W +: `DC_INDEX_W]),
    .wr_en(tag_wr_en[1]), .wr_data(tag_wr_data), .rd_data(tag_way1)
  );

  // Line store
  dc_way_ram #(.entry_t(logic [`DC_LINE_W-1:0])) line_way0_i (
    .clk(clk), .rst(rst), .index(cur_req.addr[`DC_OFFSET_W +: `DC_INDEX_W]),
    .wr_en(line_wr_en[0]), .wr_data(line_wr_data), .rd_data(line_way0)
  );

  dc_way_ram #(.entry_t(logic [`DC_LINE_W-1:0])) line_way1_i (
    .clk(clk), .rst(rst), .index(cur_req.addr[`DC_OFFSET_W +: `DC_INDEX_W]),
    .wr_en(line_wr_en[1]), .wr_data(line_wr_data), .rd_data(line_way1)
  );

endmodule

`default_nettype wire

// ==== tests/dcache_properties.sv ====
// Data cache handshake properties
// Memory request hold, core handshake exclusion and reset values

`timescale 1ns/1ps
`default_nettype none

module dcache_properties (
  input logic                 clk,
  input logic                 rst,
  input logic                 req_ready,
  input logic                 rsp_valid,
  input dc_pkg::dc_mem_req_t  mem_req,
  input logic                 mem_req_valid,
  input logic                 mem_ack
);

  int fail_count = 0;

  // Request and payload hold until the acknowledge edge
  mem_req_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid && !mem_ack |=> mem_req_valid && $stable(mem_req))
  else begin
    fail_count++;
    $error("memory request dropped or changed before acknowledge");
  end

  no_accept_in_refill: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid |-> !req_ready)
  else begin
    fail_count++;
    $error("req_ready high while a memory request is pending");
  end

  rsp_single_cycle: assert property (@(posedge clk) disable iff (rst)
    rsp_valid |=> !rsp_valid)
  else begin
    fail_count++;
    $error("rsp_valid high two cycles in a row");
  end

  reset_values: assert property (@(posedge clk) rst |=> !mem_req_valid && !rsp_valid)
  else begin
    fail_count++;
    $error("mem_req_valid or rsp_valid high after reset");
  end

endmodule

bind dcache dcache_properties props_i (
  .clk(clk), .rst(rst), .req_ready(req_ready), .rsp_valid(rsp_valid),
  .mem_req(mem_req), .mem_req_valid(mem_req_valid), .mem_ack(mem_ack)
);

`default_nettype wire

// ==== tests/dcache_tb.sv ====
// Data cache testbench
// Runs the operations of the input file against a memory model with
// random acknowledge delays, checks read data, latency and write-backs

`timescale 1ns/1ps
`default_nettype none

`include "dc_settings.svh"

module dcache_tb;

  localparam int N_OPS = 33;
  localparam int CYCLE_LIMIT = N_OPS * 20 + 200;
  localparam int MEM_WORDS = 1 << (`DC_ADDR_W - 2);

  logic                    clk = 1'b0;
  logic                    rst;
  dc_pkg::dc_req_t         req;
  logic                    req_valid;
  logic                    req_ready;
  dc_pkg::dc_rsp_t         rsp;
  logic                    rsp_valid;
  dc_pkg::dc_mem_req_t     mem_req;
  logic                    mem_req_valid;
  logic                    mem_ack;
  logic [`DC_LINE_W-1:0]   mem_fill;

  // Four words per operation for kind, address, write data and expected read data
  logic [31:0]          ops [0:4*N_OPS-1];
  logic [31:0]          mem [0:MEM_WORDS-1];
  logic [31:0]          shadow [0:MEM_WORDS-1];
  bit                   stored_line [0:MEM_WORDS/4-1];
  // Most and least recently used line address of each set
  logic [`DC_ADDR_W-`DC_OFFSET_W-1:0] mru_line [0:`DC_SETS-1];
  logic [`DC_ADDR_W-`DC_OFFSET_W-1:0] lru_line [0:`DC_SETS-1];
  dc_pkg::dc_mem_req_t  last_mem_req;
  int                   errors = 0;
  int                   checks = 0;
  int                   cycles = 0;
  int                   mem_reqs = 0;
  int                   ack_wait = 0;
  bit                   busy = 1'b0;
  logic [31:0]          rng = 32'd75480;

  dcache dut_i (
    .clk(clk), .rst(rst),
    .req(req), .req_valid(req_valid), .req_ready(req_ready),
    .rsp(rsp), .rsp_valid(rsp_valid),
    .mem_req(mem_req), .mem_req_valid(mem_req_valid),
    .mem_ack(mem_ack), .mem_fill(mem_fill)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare(input string name, input logic [127:0] got,
                         input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %0h, expected %0h", name, got, exp);
    end
  endtask

  // Memory model answers 1 to 4 cycles after a request shows up
  always @(posedge clk) begin
    int fill_base;
    int evict_base;
    mem_ack <= 1'b0;
    if (rst) begin
      busy = 1'b0;
    end else if (busy && ack_wait > 0) begin
      ack_wait--;
    end else if (busy) begin
      busy = 1'b0;
      fill_base = mem_req.fill_addr >> 2;
      evict_base = mem_req.evict_addr >> 2;
      last_mem_req = mem_req;
      mem_reqs++;
      if (mem_req.evict) begin
        if (!stored_line[mem_req.evict_addr >> 4]) begin
          errors++;
          $display("Evicted line at %h was never stored to", mem_req.evict_addr);
        end
        compare("mem_req.evict_data", mem_req.evict_data,
                {shadow[evict_base+3], shadow[evict_base+2],
                 shadow[evict_base+1], shadow[evict_base]});
        for (int k = 0; k < 4; k++) begin
          mem[evict_base+k] = mem_req.evict_data[k*32 +: 32];
        end
      end
      mem_fill <= {mem[fill_base+3], mem[fill_base+2], mem[fill_base+1], mem[fill_base]};
      mem_ack <= 1'b1;
    end else if (mem_req_valid && !mem_ack) begin
      busy = 1'b1;
      rng = xorshift(rng);
      ack_wait = rng % 4;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  // Called right after a rising edge
  task automatic run_op(input int n);
    logic [7:0]  kind;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    int          reqs_before;
    int          lat;
    int          set_idx;
    logic [`DC_ADDR_W-`DC_OFFSET_W-1:0] line_addr;
    kind = ops[4*n][7:0];
    addr = ops[4*n+1];
    wdata = ops[4*n+2];
    rdata = ops[4*n+3];
    reqs_before = mem_reqs;
    lat = 0;
    set_idx = addr[`DC_OFFSET_W +: `DC_INDEX_W];
    line_addr = addr[`DC_ADDR_W-1:`DC_OFFSET_W];
    req <= '{write: kind[0], addr: addr[`DC_ADDR_W-1:0], wdata: wdata};
    req_valid <= 1'b1;
    @(posedge clk);
    // The previous access has completed, so the cache takes this one at once
    compare("req_ready", req_ready, 1'b1);
    while (!req_ready) @(posedge clk);
    req_valid <= 1'b0;
    if (kind[0]) begin
      shadow[addr[`DC_ADDR_W-1:2]] = wdata;
      stored_line[addr[`DC_ADDR_W-1:4]] = 1'b1;
    end
    do begin
      @(posedge clk);
      lat++;
    end while (!rsp_valid);
    if (!kind[0]) compare("rsp.rdata", rsp.rdata, rdata);
    if (kind[1]) begin
      compare("rsp latency", lat, 2);
      compare("memory request count", mem_reqs - reqs_before, 0);
    end
    if (kind[2]) begin
      compare("memory request count", mem_reqs - reqs_before, 1);
      compare("mem_req.fill_addr", last_mem_req.fill_addr, {addr[`DC_ADDR_W-1:4], 4'h0});
      compare("mem_req.evict", last_mem_req.evict, kind[3]);
      if (kind[3]) begin
        compare("mem_req.evict_addr", last_mem_req.evict_addr,
                {lru_line[set_idx], 4'h0});
      end
    end
    if (mru_line[set_idx] !== line_addr) begin
      lru_line[set_idx] = mru_line[set_idx];
      mru_line[set_idx] = line_addr;
    end
  endtask

  initial begin
    int first_op;
    int test_errors;
    int tests;
    rst = 1'b1;
    req = '0;
    req_valid = 1'b0;
    mem_ack = 1'b0;
    mem_fill = '0;
    tests = 0;
    first_op = 0;
    test_errors = 0;
    $readmemh("tests/dcache_input.txt", ops);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {16'hC0DE, 16'(i * 4)};
      shadow[i] = mem[i];
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int n = 0; n < N_OPS; n++) begin
      run_op(n);
      if (n == N_OPS - 1 || ops[4*n+4][7:4] != ops[4*n][7:4]) begin
        tests++;
        $display("test %0d: %0d ops, %s", ops[4*n][7:4], n - first_op + 1,
                 (errors == test_errors) ? "ok" : "FAIL");
        test_errors = errors;
        first_op = n + 1;
      end
    end
    errors += dut_i.props_i.fail_count;
    $display("%0d tests, %0d ops, %0d checks, %0d errors", tests, N_OPS, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/dcache_input.txt ====
// kind addr wdata expected_rdata, all hex; kind high nibble is the test number,
// low nibble flags: 1 store, 2 expect hit, 4 expect miss, 8 expect dirty evict
14 0010 00000000 C0DE0010
22 0014 00000000 C0DE0014
22 001C 00000000 C0DE001C
33 0018 11112222 00000000
32 0018 00000000 11112222
32 0010 00000000 C0DE0010
45 0030 30303030 00000000
45 0134 31313131 00000000
42 0030 00000000 30303030
4C 0238 00000000 C0DE0238
4C 0334 00000000 C0DE0334
54 0134 00000000 31313131
54 0030 00000000 30303030
61 0004 0600A004 00000000
60 7F24 00000000 C0DE7F24
60 0018 00000000 11112222
61 1548 DEADBEEF 00000000
60 0254 00000000 C0DE0254
61 3360 12345678 00000000
60 0134 00000000 31313131
60 447C 00000000 C0DE447C
61 0884 0BADF00D 00000000
60 6E98 00000000 C0DE6E98
60 0B10 00000000 C0DE0B10
61 22A0 CAFEF00D 00000000
60 11B8 00000000 C0DE11B8
61 0EC4 55AA55AA 00000000
60 1C10 00000000 C0DE1C10
60 2DD0 00000000 C0DE2DD0
61 3AE8 77665544 00000000
60 09F0 00000000 C0DE09F0
60 0018 00000000 11112222
60 0004 00000000 0600A004

// ==== all.f ====
+incdir+logic
logic/dc_pkg.sv
logic/dc_way_ram.sv
logic/dc_lookup.sv
logic/dc_ctrl.sv
logic/dcache.sv
tests/dcache_properties.sv
tests/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - include_dirs:
      - logic
    files:
      - logic/dc_pkg.sv
      - logic/dc_way_ram.sv
      - logic/dc_lookup.sv
      - logic/dc_ctrl.sv
      - logic/dcache.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/dcache_properties.sv
      - tests/dcache_tb.sv
